// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert -Wno-fatal --top-module audio_out_tb -f all.f
	@out=$$(./obj_dir/Vaudio_out_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== all.f ====
logic/audio_pkg.sv
logic/audio_cfg_regs.sv
logic/audio_sample_latch.sv
logic/audio_gain.sv
logic/audio_sd_dac.sv
logic/audio_out_top.sv
verification/audio_out_sva.sv
verification/audio_out_tb.sv

// ==== logic/audio_cfg_regs.sv ====
////////////////////
// Audio configuration registers
// Control and per-channel volume, host writable with read-back
////////////////////

module audio_cfg_regs (
    input  logic                         sample,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  audio_pkg::cfg_addr_t         cfg_addr,
    input  logic [audio_pkg::CFG_DW-1:0] cfg_wdata,
    output logic [audio_pkg::CFG_DW-1:0] cfg_rdata,
    output logic                         snd_signed,
    output logic                         stereo,
    output logic                         mute,
    output audio_pkg::vol_t              vol_left,
    output audio_pkg::vol_t              vol_right
);

    import audio_pkg::*;

    localparam int VOL_W = $bits(vol_t);

    logic [CTRL_W-1:0] ctrl;
    vol_t              vol_l_q;
    vol_t              vol_r_q;

    // Register writes, unused address drops the data
    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            ctrl    <= CTRL_RESET;
            vol_l_q <= UNITY_VOL;
            vol_r_q <= UNITY_VOL;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL: begin
                    ctrl <= cfg_wdata[CTRL_W-1:0];
                end
                CFG_VOL_L: begin
                    vol_l_q <= cfg_wdata[VOL_W-1:0];
                end
                CFG_VOL_R: begin
                    vol_r_q <= cfg_wdata[VOL_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Read-back mux, zero extended
    always_comb begin
        case (cfg_addr)
            CFG_CTRL: begin
                cfg_rdata = CFG_DW'(ctrl);
            end
            CFG_VOL_L: begin
                cfg_rdata = CFG_DW'(vol_l_q);
            end
            CFG_VOL_R: begin
                cfg_rdata = CFG_DW'(vol_r_q);
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

    // Steering outputs for the sample path
    assign snd_signed = ctrl[CTRL_SIGNED];
    assign stereo     = ctrl[CTRL_STEREO];
    assign mute       = ctrl[CTRL_MUTE];
    assign vol_left   = vol_l_q;
    assign vol_right  = vol_r_q;

endmodule

// ==== logic/audio_gain.sv ====
////////////////////
// Audio gain stage
// Volume scaling with saturation and mute
////////////////////

module audio_gain #(
    parameter int SND_W = 16
) (
    input  logic                    sample,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic signed [SND_W-1:0] in_sample,
    input  audio_pkg::vol_t         vol,
    input  logic                    mute,
    output logic                    out_valid,
    output logic signed [SND_W-1:0] out_level
);

    import audio_pkg::*;

    // Room for the full product of sample and volume code
    localparam int PW = SND_W + $bits(vol_t) + 1;

    logic signed [PW-1:0]    prod;
    logic signed [PW-1:0]    scaled;
    logic        [PW-SND_W:0] top_bits;
    logic signed [SND_W-1:0] clamped;

    // Volume code is unsigned, keep it positive
    assign prod   = in_sample * $signed({1'b0, vol});
    assign scaled = prod >>> GAIN_SHIFT;

    // Fits when everything above the sign bit repeats it
    assign top_bits = scaled[PW-1:SND_W-1];

    always_comb begin
        if (top_bits == '0 || top_bits == '1) begin
            clamped = scaled[SND_W-1:0];
        end else if (scaled[PW-1]) begin
            // Negative overflow
            clamped = {1'b1, {(SND_W-1){1'b0}}};
        end else begin
            clamped = {1'b0, {(SND_W-1){1'b1}}};
        end
    end

    // Level holds between valid pulses
    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_level <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_level <= mute ? '0 : clamped;
            end
        end
    end

endmodule

// ==== logic/audio_out_top.sv ====
////////////////////
// Audio output stage
// Registers, sample latch, gain and sigma-delta pins
////////////////////

module audio_out_top #(
    parameter int SND_W = 16
) (
    input  logic                         sample,
    input  logic                         rst_n,
    input  logic                         snd_stb,
    input  logic                         cfg_we,
    input  logic        [SND_W-1:0]      snd_left,
    input  logic        [SND_W-1:0]      snd_right,
    input  audio_pkg::cfg_addr_t         cfg_addr,
    input  logic [audio_pkg::CFG_DW-1:0] cfg_wdata,
    output logic [audio_pkg::CFG_DW-1:0] cfg_rdata,
    output logic                         level_valid,
    output logic signed [SND_W-1:0]      level_left,
    output logic signed [SND_W-1:0]      level_right,
    output logic                         audio_l,
    output logic                         audio_r
);

    import audio_pkg::*;

    // Register block outputs
    logic snd_signed;
    logic stereo;
    logic mute;
    vol_t vol_left;
    vol_t vol_right;

    // Latched samples
    logic                    lat_valid;
    logic signed [SND_W-1:0] lat_left;
    logic signed [SND_W-1:0] lat_right;

    audio_cfg_regs u_regs (
        .sample     ( sample     ),
        .rst_n      ( rst_n      ),
        .cfg_we     ( cfg_we     ),
        .cfg_addr   ( cfg_addr   ),
        .cfg_wdata  ( cfg_wdata  ),
        .cfg_rdata  ( cfg_rdata  ),
        .snd_signed ( snd_signed ),
        .stereo     ( stereo     ),
        .mute       ( mute       ),
        .vol_left   ( vol_left   ),
        .vol_right  ( vol_right  )
    );

    audio_sample_latch #(
        .SND_W ( SND_W )
    ) u_latch (
        .sample     ( sample     ),
        .rst_n      ( rst_n      ),
        .snd_stb    ( snd_stb    ),
        .snd_signed ( snd_signed ),
        .stereo     ( stereo     ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .lat_valid  ( lat_valid  ),
        .lat_left   ( lat_left   ),
        .lat_right  ( lat_right  )
    );

    // Both channels share timing, left valid drives the output
    audio_gain #(
        .SND_W ( SND_W )
    ) u_gain_l (
        .sample    ( sample      ),
        .rst_n     ( rst_n       ),
        .in_valid  ( lat_valid   ),
        .in_sample ( lat_left    ),
        .vol       ( vol_left    ),
        .mute      ( mute        ),
        .out_valid ( level_valid ),
        .out_level ( level_left  )
    );

    audio_gain #(
        .SND_W ( SND_W )
    ) u_gain_r (
        .sample    ( sample      ),
        .rst_n     ( rst_n       ),
        .in_valid  ( lat_valid   ),
        .in_sample ( lat_right   ),
        .vol       ( vol_right   ),
        .mute      ( mute        ),
        .out_valid (             ),
        .out_level ( level_right )
    );

    // One-bit pins
    audio_sd_dac #(
        .SND_W ( SND_W )
    ) u_dac_l (
        .sample  ( sample      ),
        .rst_n   ( rst_n       ),
        .load    ( level_valid ),
        .level   ( level_left  ),
        .dac_out ( audio_l     )
    );

    audio_sd_dac #(
        .SND_W ( SND_W )
    ) u_dac_r (
        .sample  ( sample      ),
        .rst_n   ( rst_n       ),
        .load    ( level_valid ),
        .level   ( level_right ),
        .dac_out ( audio_r     )
    );

endmodule

// ==== logic/audio_pkg.sv ====
////////////////////
// Audio output package
// Register map, control bits and gain constants
////////////////////

package audio_pkg;

    // Host register port
    localparam int CFG_DW = 8;

    typedef logic [1:0] cfg_addr_t;

    // Volume code, gain is code / 8
    typedef logic [3:0] vol_t;

    // Register addresses, address 3 is unused
    localparam cfg_addr_t CFG_CTRL  = 2'd0;
    localparam cfg_addr_t CFG_VOL_L = 2'd1;
    localparam cfg_addr_t CFG_VOL_R = 2'd2;

    // Control register layout
    localparam int CTRL_W      = 3;
    localparam int CTRL_SIGNED = 0;
    localparam int CTRL_STEREO = 1;
    localparam int CTRL_MUTE   = 2;

    // Signed stereo game, not muted
    localparam logic [CTRL_W-1:0] CTRL_RESET = 3'b011;

    // Gain arithmetic
    localparam int GAIN_SHIFT = 3;

    // Code 8 passes samples unchanged
    localparam vol_t UNITY_VOL = 4'd8;

endpackage

// ==== logic/audio_sample_latch.sv ====
////////////////////
// Game sample latch
// Captures samples on snd_stb, mono copy and sign fix
////////////////////

module audio_sample_latch #(
    parameter int SND_W = 16
) (
    input  logic                    sample,
    input  logic                    rst_n,
    input  logic                    snd_stb,
    input  logic                    snd_signed,
    input  logic                    stereo,
    input  logic        [SND_W-1:0] snd_left,
    input  logic        [SND_W-1:0] snd_right,
    output logic                    lat_valid,
    output logic signed [SND_W-1:0] lat_left,
    output logic signed [SND_W-1:0] lat_right
);

    logic [SND_W-1:0] src_right;
    logic [SND_W-1:0] cnv_left;
    logic [SND_W-1:0] cnv_right;
    logic             msb_flip;

    // Mono games only drive the left channel
    assign src_right = stereo ? snd_right : snd_left;

    // Unsigned to two's complement is an MSB flip
    assign msb_flip  = ~snd_signed;
    assign cnv_left  = {snd_left[SND_W-1] ^ msb_flip, snd_left[SND_W-2:0]};
    assign cnv_right = {src_right[SND_W-1] ^ msb_flip, src_right[SND_W-2:0]};

    // Valid follows the strobe by one cycle
    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            lat_valid <= 1'b0;
        end else begin
            lat_valid <= snd_stb;
        end
    end

    // Sample payload
    always_ff @(posedge sample) begin
        if (snd_stb) begin
            lat_left  <= $signed(cnv_left);
            lat_right <= $signed(cnv_right);
        end
    end

endmodule

// ==== logic/audio_sd_dac.sv ====
////////////////////
// Sigma-delta DAC
// First-order modulator for a one-bit audio pin
////////////////////

module audio_sd_dac #(
    parameter int SND_W = 16
) (
    input  logic                    sample,
    input  logic                    rst_n,
    input  logic                    load,
    input  logic signed [SND_W-1:0] level,
    output logic                    dac_out
);

    logic signed [SND_W-1:0] held;
    logic        [SND_W-1:0] held_ob;
    logic        [SND_W-1:0] acc;
    logic        [SND_W:0]   acc_sum;

    // Offset binary, so full negative scale gives no ones
    assign held_ob = {~held[SND_W-1], held[SND_W-2:0]};

    // Carry is the density bit
    assign acc_sum = {1'b0, acc} + {1'b0, held_ob};

    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            held    <= '0;
            acc     <= '0;
            dac_out <= 1'b0;
        end else begin
            if (load) begin
                held <= level;
            end
            acc     <= acc_sum[SND_W-1:0];
            dac_out <= acc_sum[SND_W];
        end
    end

endmodule

// ==== verification/audio_out_sva.sv ====
////////////////////
// Audio output assertions
// Strobe timing, mute and reset checks on the top level
////////////////////

module audio_out_sva #(
    parameter int SND_W = 16
) (
    input logic             sample,
    input logic             rst_n,
    input logic             snd_stb,
    input logic             lat_valid,
    input logic             mute,
    input logic             level_valid,
    input logic [SND_W-1:0] level_left,
    input logic [SND_W-1:0] level_right,
    input logic             audio_l,
    input logic             audio_r
);

    // Two register stages between strobe and level
    a_valid_after_stb: assert property (@(posedge sample) disable iff (!rst_n)
        snd_stb |-> ##2 level_valid)
        else $error("level_valid did not follow snd_stb by two cycles");

    a_stb_before_valid: assert property (@(posedge sample) disable iff (!rst_n)
        level_valid |-> $past(snd_stb, 2))
        else $error("level_valid without snd_stb two cycles earlier");

    // Muted sample at the gain stage comes out as zero
    a_mute_zero: assert property (@(posedge sample) disable iff (!rst_n)
        (lat_valid && mute) |=> (level_left == '0 && level_right == '0))
        else $error("levels not zero after a muted sample");

    a_pins_in_reset: assert property (@(posedge sample)
        !rst_n |-> (!audio_l && !audio_r))
        else $error("audio pins high during reset");

endmodule

bind audio_out_top audio_out_sva #(
    .SND_W ( SND_W )
) u_sva (
    .sample      ( sample      ),
    .rst_n       ( rst_n       ),
    .snd_stb     ( snd_stb     ),
    .lat_valid   ( lat_valid   ),
    .mute        ( mute        ),
    .level_valid ( level_valid ),
    .level_left  ( level_left  ),
    .level_right ( level_right ),
    .audio_l     ( audio_l     ),
    .audio_r     ( audio_r     )
);

// ==== verification/audio_out_tb.sv ====
////////////////////
// Audio output stage testbench
// Directed tests for registers, sample path and sigma-delta pins
////////////////////

module audio_out_tb;

    localparam int SND_W      = 16;
    localparam int MAX_CYCLES = 140000;
    localparam int WINDOW     = 65536;

    logic             sample;
    logic             rst_n;
    logic             snd_stb;
    logic             cfg_we;
    logic [SND_W-1:0] snd_left;
    logic [SND_W-1:0] snd_right;
    logic [1:0]       cfg_addr;
    logic [7:0]       cfg_wdata;
    logic [7:0]       cfg_rdata;
    logic             level_valid;
    logic [SND_W-1:0] level_left;
    logic [SND_W-1:0] level_right;
    logic             audio_l;
    logic             audio_r;

    // Shadow of the register block, used by the model
    logic [2:0]       cur_ctrl;
    logic [3:0]       cur_vol_l;
    logic [3:0]       cur_vol_r;

    logic [SND_W-1:0] exp_l[$];
    logic [SND_W-1:0] exp_r[$];
    logic             stb_d1;
    logic             stb_d2;
    logic [SND_W-1:0] last_l;
    logic [SND_W-1:0] last_r;
    int               errors;
    int               tests_passed;
    int               tests_failed;
    int               cycles;

    audio_out_top #(
        .SND_W ( SND_W )
    ) i_dut (
        .sample      ( sample      ),
        .rst_n       ( rst_n       ),
        .snd_stb     ( snd_stb     ),
        .cfg_we      ( cfg_we      ),
        .snd_left    ( snd_left    ),
        .snd_right   ( snd_right   ),
        .cfg_addr    ( cfg_addr    ),
        .cfg_wdata   ( cfg_wdata   ),
        .cfg_rdata   ( cfg_rdata   ),
        .level_valid ( level_valid ),
        .level_left  ( level_left  ),
        .level_right ( level_right ),
        .audio_l     ( audio_l     ),
        .audio_r     ( audio_r     )
    );

    always #20 sample = ~sample;

    // Run limit
    always @(posedge sample) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Reference model of mono, unsigned, gain, clamp and mute
    function automatic logic [SND_W-1:0] model_level(input logic [SND_W-1:0] raw,
                                                     input logic is_signed,
                                                     input logic [3:0] vol,
                                                     input logic muted);
        int s;
        int p;
        if (is_signed) begin
            s = int'($signed(raw));
        end else begin
            s = int'(raw) - 32768;
        end
        p = (s * int'(vol)) >>> 3;
        if (p > 32767) begin
            p = 32767;
        end else if (p < -32768) begin
            p = -32768;
        end
        if (muted) begin
            p = 0;
        end
        return p[SND_W-1:0];
    endfunction

    // Output monitor, checks timing, values and hold
    always @(negedge sample) begin
        if (!rst_n) begin
            stb_d1 = 1'b0;
            stb_d2 = 1'b0;
            last_l = '0;
            last_r = '0;
        end else begin
            compare("level_valid", level_valid, stb_d2);
            if (level_valid) begin
                if (exp_l.size() == 0) begin
                    errors++;
                    $display("An output sample appeared with no strobe waiting for it");
                end else begin
                    compare("level_left", level_left, exp_l.pop_front());
                    compare("level_right", level_right, exp_r.pop_front());
                end
            end else begin
                compare("level_left hold", level_left, last_l);
                compare("level_right hold", level_right, last_r);
            end
            last_l = level_left;
            last_r = level_right;
            stb_d2 = stb_d1;
            stb_d1 = snd_stb;
        end
    end

    task automatic reg_write(input logic [1:0] addr, input logic [7:0] data);
        @(posedge sample);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge sample);
        cfg_we    <= 1'b0;
        case (addr)
            2'd0: cur_ctrl = data[2:0];
            2'd1: cur_vol_l = data[3:0];
            2'd2: cur_vol_r = data[3:0];
            default: begin
            end
        endcase
    endtask

    task automatic read_expect(input logic [1:0] addr, input logic [7:0] expected,
                               input string name);
        @(posedge sample);
        cfg_addr <= addr;
        @(negedge sample);
        compare(name, cfg_rdata, expected);
    endtask

    task automatic strobe(input logic [SND_W-1:0] left, input logic [SND_W-1:0] right);
        logic [SND_W-1:0] src_r;
        src_r = cur_ctrl[1] ? right : left;
        @(posedge sample);
        snd_stb   <= 1'b1;
        snd_left  <= left;
        snd_right <= right;
        exp_l.push_back(model_level(left, cur_ctrl[0], cur_vol_l, cur_ctrl[2]));
        exp_r.push_back(model_level(src_r, cur_ctrl[0], cur_vol_r, cur_ctrl[2]));
    endtask

    task automatic idle();
        @(posedge sample);
        snd_stb <= 1'b0;
    endtask

    // Wait until every strobed sample has come out
    task automatic drain();
        idle();
        while (exp_l.size() != 0) begin
            @(posedge sample);
        end
    endtask

    task automatic end_test(input string name, input int base);
        if (errors == base) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - base);
        end
    endtask

    task automatic reset_regs_test();
        logic [7:0] val;
        int         base;
        base = errors;
        @(negedge sample);
        compare("audio_l", audio_l, 0);
        compare("audio_r", audio_r, 0);
        compare("level_valid", level_valid, 0);
        read_expect(2'd0, 8'h03, "ctrl");
        read_expect(2'd1, 8'h08, "vol_left");
        read_expect(2'd2, 8'h08, "vol_right");
        read_expect(2'd3, 8'h00, "unused");
        repeat (4) begin
            val = 8'($urandom);
            reg_write(2'd0, val);
            read_expect(2'd0, {5'b0, val[2:0]}, "ctrl");
            val = 8'($urandom);
            reg_write(2'd1, val);
            read_expect(2'd1, {4'b0, val[3:0]}, "vol_left");
            val = 8'($urandom);
            reg_write(2'd2, val);
            read_expect(2'd2, {4'b0, val[3:0]}, "vol_right");
            reg_write(2'd3, 8'($urandom));
            read_expect(2'd3, 8'h00, "unused");
        end
        reg_write(2'd0, 8'h03);
        reg_write(2'd1, 8'h08);
        reg_write(2'd2, 8'h08);
        end_test("reset and registers", base);
    endtask

    task automatic stereo_unity_test();
        int base;
        base = errors;
        for (int i = 0; i < 20; i++) begin
            strobe(16'($urandom), 16'($urandom));
            // Every fourth pair runs back to back with the next
            if (i % 4 != 1) begin
                idle();
            end
        end
        drain();
        end_test("stereo signed unity", base);
    endtask

    task automatic mono_unsigned_test();
        int base;
        base = errors;
        reg_write(2'd0, 8'h01);
        repeat (6) strobe(16'($urandom), 16'($urandom));
        drain();
        reg_write(2'd0, 8'h02);
        strobe(16'h0000, 16'hFFFF);
        strobe(16'h8000, 16'h7FFF);
        repeat (4) strobe(16'($urandom), 16'($urandom));
        drain();
        reg_write(2'd0, 8'h00);
        repeat (4) strobe(16'($urandom), 16'($urandom));
        drain();
        reg_write(2'd0, 8'h03);
        end_test("mono and unsigned", base);
    endtask

    task automatic volume_mute_test();
        logic [3:0]       codes[4] = '{4'd0, 4'd3, 4'd8, 4'd15};
        logic [SND_W-1:0] edges[4] = '{16'h7FFF, 16'h8000, 16'h0001, 16'hFFFF};
        int               base;
        base = errors;
        foreach (codes[k]) begin
            reg_write(2'd1, {4'h0, codes[k]});
            reg_write(2'd2, {4'h0, codes[3-k]});
            foreach (edges[j]) begin
                strobe(edges[j], edges[3-j]);
            end
            repeat (4) strobe(16'($urandom), 16'($urandom));
            drain();
        end
        // Nonzero gain on both channels so mute has something to silence
        reg_write(2'd1, 8'h05);
        reg_write(2'd2, 8'h0B);
        reg_write(2'd0, 8'h07);
        repeat (4) strobe(16'($urandom), 16'($urandom));
        drain();
        reg_write(2'd0, 8'h03);
        repeat (4) strobe(16'($urandom), 16'($urandom));
        drain();
        reg_write(2'd1, 8'h08);
        reg_write(2'd2, 8'h08);
        end_test("volume, saturation and mute", base);
    endtask

    // Count pin ones over one full modulator window
    task automatic density_window(input logic [SND_W-1:0] left, input logic [SND_W-1:0] right);
        int ones_l;
        int ones_r;
        int want_l;
        int want_r;
        want_l = int'($signed(model_level(left, cur_ctrl[0], cur_vol_l, cur_ctrl[2]))) + 32768;
        want_r = int'($signed(model_level(right, cur_ctrl[0], cur_vol_r, cur_ctrl[2]))) + 32768;
        strobe(left, right);
        strobe(left, right);
        drain();
        repeat (3) @(posedge sample);
        ones_l = 0;
        ones_r = 0;
        repeat (WINDOW) begin
            @(negedge sample);
            ones_l += int'(audio_l);
            ones_r += int'(audio_r);
        end
        compare("audio_l ones", ones_l, want_l);
        compare("audio_r ones", ones_r, want_r);
    endtask

    task automatic density_test();
        logic [SND_W-1:0] lvl;
        int               base;
        base = errors;
        lvl = 16'($urandom);
        density_window(lvl, lvl ^ 16'h5A5A);
        density_window(16'h7FFF, 16'h8000);
        end_test("sigma-delta density", base);
    endtask

    initial begin
        void'($urandom(28935));
        sample    = 1'b0;
        rst_n     = 1'b0;
        snd_stb   = 1'b0;
        cfg_we    = 1'b0;
        snd_left  = '0;
        snd_right = '0;
        cfg_addr  = 2'd0;
        cfg_wdata = 8'h00;
        cur_ctrl  = 3'b011;
        cur_vol_l = 4'd8;
        cur_vol_r = 4'd8;
        errors    = 0;
        cycles    = 0;
        repeat (4) @(posedge sample);
        rst_n <= 1'b1;
        reset_regs_test();
        stereo_unity_test();
        mono_unsigned_test();
        volume_mute_test();
        density_test();
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
